//--- Makefile
SRCS := $(filter-out +%,$(shell cat list.f)) common/mem_system_defines.svh

.PHONY: run clean

run: obj_dir/Vmem_system_tb
	./obj_dir/Vmem_system_tb

obj_dir/Vmem_system_tb: list.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module mem_system_tb -f list.f

clean:
	rm -rf obj_dir

//--- bench/mem_system_chk.sv
/*
 * memory system protocol checks
 * Done, Stall, CacheHit and err rules at the top level
 */
`timescale 1ns/100ps

module mem_system_chk (
    input logic clk,
    input logic rst_n,
    input logic Done,
    input logic Stall,
    input logic CacheHit,
    input logic err
);

    done_single: assert property (@(posedge clk) disable iff (!rst_n) Done |=> !Done)
        else $error("Done high in two cycles in a row");

    done_no_stall: assert property (@(posedge clk) disable iff (!rst_n) !(Done && Stall))
        else $error("Done and Stall high together");

    err_no_done: assert property (@(posedge clk) disable iff (!rst_n) !(err && Done))
        else $error("err high together with Done");

    hit_with_done: assert property (@(posedge clk) disable iff (!rst_n) CacheHit |-> Done)
        else $error("CacheHit high without Done");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !Done && !Stall && !CacheHit && !err)
        else $error("outputs not low after reset");

endmodule

bind mem_system mem_system_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .Done     (Done),
    .Stall    (Stall),
    .CacheHit (CacheHit),
    .err      (err)
);

//--- bench/mem_system_tb.sv
/*
 * memory system testbench
 * directed tests of the two-way cache and banked memory, checked
 * against a shadow memory and a per-set replacement model
 */
`timescale 1ns/100ps
`include "mem_system_defines.svh"

module mem_system_tb;

    import mem_system_pkg::*;

    // about 70 accesses at under 40 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int SETS = 1 << `INDEX_W;

    logic  clk;
    logic  rst_n;
    addr_t Addr;
    data_t DataIn;
    logic  Rd;
    logic  Wr;
    data_t DataOut;
    logic  Done;
    logic  Stall;
    logic  CacheHit;
    logic  err;

    logic [15:0] lfsr;
    int          cycles = 0;
    data_t       shadow [addr_t];
    tag_t        m_tag [SETS][2];
    logic        m_valid [SETS][2];
    logic        m_dirty [SETS][2];
    logic        m_lru [SETS];

    mem_system u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .Addr     (Addr),
        .DataIn   (DataIn),
        .Rd       (Rd),
        .Wr       (Wr),
        .DataOut  (DataOut),
        .Done     (Done),
        .Stall    (Stall),
        .CacheHit (CacheHit),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("simulation timed out, Done never arrived");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t i, input word_sel_t w);
        return {t, i, w, 1'b0};
    endfunction

    task automatic compare_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compare_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s took %0d cycles, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // predicts hit and read data, then applies the access to the model
    task automatic model_access(input logic is_wr, input addr_t a, input data_t d,
                                output logic exp_hit, output data_t exp_data);
        addr_fields_t f;
        logic         w;
        f        = addr_fields_t'(a);
        exp_data = shadow.exists(a) ? shadow[a] : '0;
        exp_hit  = 1'b0;
        w        = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[f.index][i] && m_tag[f.index][i] == f.tag) begin
                exp_hit = 1'b1;
                w       = i[0];
            end
        end
        if (!exp_hit) begin
            // invalid way 0, then invalid way 1, then the LRU way
            w = !m_valid[f.index][0] ? 1'b0 : !m_valid[f.index][1] ? 1'b1 : m_lru[f.index];
            m_tag[f.index][w]   = f.tag;
            m_valid[f.index][w] = 1'b1;
            m_dirty[f.index][w] = 1'b0;
        end
        if (is_wr) begin
            m_dirty[f.index][w] = 1'b1;
            shadow[a]           = d;
        end
        m_lru[f.index] = ~w;
    endtask

    task automatic run_access(input logic is_wr, input addr_t a, input data_t d);
        logic  exp_hit;
        data_t exp_data;
        int    lat;
        model_access(is_wr, a, d, exp_hit, exp_data);
        @(posedge clk);
        Rd     <= !is_wr;
        Wr     <= is_wr;
        Addr   <= a;
        DataIn <= d;
        @(posedge clk);
        Rd <= 1'b0;
        Wr <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!Done) begin
            compare_bit(Stall, 1'b1, $sformatf("Stall during miss at %h", a));
            @(negedge clk);
            lat++;
        end
        compare_bit(CacheHit, exp_hit, $sformatf("CacheHit at %h", a));
        if (!is_wr) begin
            compare_data(DataOut, exp_data, $sformatf("DataOut at %h", a));
        end
        if (exp_hit) begin
            compare_latency(lat, 1, $sformatf("hit at %h", a));
        end
    endtask

    task automatic run_error(input addr_t a, input logic both);
        data_t d;
        d = lfsr_bits(`DATA_W);
        @(posedge clk);
        Rd     <= 1'b1;
        Wr     <= both;
        Addr   <= a;
        DataIn <= d;
        @(posedge clk);
        Rd <= 1'b0;
        Wr <= 1'b0;
        @(negedge clk);
        compare_bit(err, 1'b1, "err after a bad request");
        compare_bit(Done, 1'b0, "Done after a bad request");
        compare_bit(Stall, 1'b0, "Stall after a bad request");
        compare_bit(CacheHit, 1'b0, "CacheHit after a bad request");
        @(negedge clk);
        compare_bit(err, 1'b0, "err one cycle later");
    endtask

    task automatic test_cold_miss();
        run_access(1'b0, make_addr(5'd1, 8'h10, 2'd2), '0);
        run_access(1'b0, make_addr(5'd1, 8'h10, 2'd2), '0);
    endtask

    task automatic test_write_read();
        tag_t t;
        t = tag_t'(lfsr_bits(`TAG_W));
        run_access(1'b1, make_addr(t, 8'h20, 2'd1), lfsr_bits(`DATA_W));
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            run_access(1'b0, make_addr(t, 8'h20, word_sel_t'(w)), '0);
        end
    endtask

    task automatic test_lru();
        tag_t ta;
        ta = tag_t'(lfsr_bits(`TAG_W));
        run_access(1'b0, make_addr(ta, 8'h30, 2'd0), '0);
        run_access(1'b0, make_addr(ta ^ 5'd1, 8'h30, 2'd1), '0);
        run_access(1'b0, make_addr(ta, 8'h30, 2'd2), '0);
        run_access(1'b1, make_addr(ta ^ 5'd2, 8'h30, 2'd3), lfsr_bits(`DATA_W));
        run_access(1'b0, make_addr(ta, 8'h30, 2'd3), '0);
        run_access(1'b0, make_addr(ta ^ 5'd1, 8'h30, 2'd1), '0);
        run_access(1'b0, make_addr(ta ^ 5'd2, 8'h30, 2'd3), '0);
    endtask

    task automatic test_write_back();
        tag_t t;
        t = tag_t'(lfsr_bits(`TAG_W));
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            run_access(1'b1, make_addr(t, 8'h44, word_sel_t'(w)), lfsr_bits(`DATA_W));
        end
        run_access(1'b0, make_addr(t ^ 5'd5, 8'h44, 2'd0), '0);
        run_access(1'b0, make_addr(t ^ 5'd6, 8'h44, 2'd0), '0);
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            run_access(1'b0, make_addr(t, 8'h44, word_sel_t'(w)), '0);
        end
    endtask

    task automatic test_errors();
        addr_t a;
        a = make_addr(tag_t'(lfsr_bits(`TAG_W)), 8'h60, 2'd2);
        run_access(1'b1, a, lfsr_bits(`DATA_W));
        run_error(a | addr_t'(1), 1'b0);
        run_error(a, 1'b1);
        run_access(1'b0, a, '0);
    endtask

    task automatic test_random_mix();
        logic [15:0] v;
        addr_t       a;
        for (int n = 0; n < 40; n++) begin
            v = lfsr_bits(1);
            a = make_addr(tag_t'(lfsr_bits(2)), index_t'(16'h0050 | lfsr_bits(2)),
                          word_sel_t'(lfsr_bits(2)));
            run_access(v[0], a, lfsr_bits(`DATA_W));
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        Rd       = 1'b0;
        Wr       = 1'b0;
        Addr     = '0;
        DataIn   = '0;
        lfsr     = 16'd36127;
        for (int i = 0; i < SETS; i++) begin
            m_valid[i][0] = 1'b0;
            m_valid[i][1] = 1'b0;
            m_dirty[i][0] = 1'b0;
            m_dirty[i][1] = 1'b0;
            m_lru[i]      = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_cold_miss();
        test_write_read();
        test_lru();
        test_write_back();
        test_errors();
        test_random_mix();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- cache/cache_ctrl.sv
/*
 * cache controller
 * request check, hit and victim selection with one LRU bit per set,
 * write-back of dirty victims and line fill from banked memory
 */
`timescale 1ns/100ps
`include "mem_system_defines.svh"

module cache_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mem_system_pkg::addr_t        Addr,
    input  mem_system_pkg::data_t        DataIn,
    input  logic                         rd_req,
    input  logic                         wr_req,
    input  mem_system_pkg::way_status_t  status0,
    input  mem_system_pkg::way_status_t  status1,
    input  mem_system_pkg::data_t        way_rdata,
    input  logic                         mem_stall,
    output mem_system_pkg::addr_fields_t fields,
    output mem_system_pkg::way_cmd_t     cmd0,
    output mem_system_pkg::way_cmd_t     cmd1,
    output logic                         way_sel,
    output mem_system_pkg::mem_req_t     mem_req,
    output logic                         done,
    output logic                         stall,
    output logic                         cache_hit,
    output logic                         err
);

    import mem_system_pkg::*;

    localparam int        SETS      = 1 << `INDEX_W;
    localparam word_sel_t LAST_WORD = word_sel_t'(`WORDS_PER_LINE - 1);

    ctrl_state_t         state;
    ctrl_state_t         state_nxt;
    addr_t               req_addr;
    data_t               req_data;
    logic                req_wr;
    logic [SETS-1:0]     lru_q;
    logic                victim_q;
    word_sel_t           cnt;
    word_sel_t           ret_cnt;
    logic [`MEM_LAT-1:0] pend;
    logic                hit_any;
    logic                pick_way;
    logic                take;
    logic                bad;
    logic                landing;
    logic                mem_accept;
    logic                fill_accept;
    way_status_t         victim_st;
    way_cmd_t            cmd_base;

    assign fields  = addr_fields_t'(req_addr);
    assign hit_any = status0.hit | status1.hit;

    // invalid way 0, then invalid way 1, then the LRU way
    assign pick_way = !status0.valid ? 1'b0 :
                      !status1.valid ? 1'b1 : lru_q[fields.index];

    assign way_sel   = (state == COMPARE) ? (hit_any ? status1.hit : pick_way) : victim_q;
    assign victim_st = way_sel ? status1 : status0;

    assign done      = (state == COMPARE && hit_any) || state == RETRY;
    assign cache_hit = state == COMPARE && hit_any;
    assign err       = state == ERROR;
    assign stall     = (state == COMPARE && !hit_any) || state == WRITE_BACK ||
                       state == FILL || state == FILL_WAIT;

    // new requests are taken whenever stall is low, including the Done cycle
    assign take = !stall && (rd_req || wr_req);
    assign bad  = Addr[0] || (rd_req && wr_req);

    assign mem_req.rd    = state == FILL;
    assign mem_req.wr    = state == WRITE_BACK;
    assign mem_req.addr  = (state == WRITE_BACK) ?
                           {victim_st.tag, fields.index, cnt, 1'b0} :
                           {fields.tag, fields.index, cnt, 1'b0};
    // shared write bus: victim word to memory, processor word to the ways
    assign mem_req.wdata = (state == WRITE_BACK) ? way_rdata : req_data;

    assign mem_accept  = (mem_req.rd || mem_req.wr) && !mem_stall;
    assign fill_accept = mem_req.rd && !mem_stall;
    assign landing     = pend[`MEM_LAT-1];

    always_comb begin
        state_nxt = state;
        case (state)
            COMPARE:    if (!hit_any) state_nxt = (victim_st.valid && victim_st.dirty) ?
                                                  WRITE_BACK : FILL;
                        else state_nxt = IDLE;
            WRITE_BACK: if (mem_accept && cnt == LAST_WORD) state_nxt = FILL;
            FILL:       if (mem_accept && cnt == LAST_WORD) state_nxt = FILL_WAIT;
            FILL_WAIT:  if (landing && ret_cnt == LAST_WORD) state_nxt = RETRY;
            default:    state_nxt = IDLE;
        endcase
        if (take) begin
            state_nxt = bad ? ERROR : COMPARE;
        end
    end

    always_comb begin
        cmd_base           = '0;
        cmd_base.word      = fields.word;
        case (state)
            COMPARE, RETRY: begin
                if (done && req_wr) begin
                    cmd_base.write     = 1'b1;
                    cmd_base.set_dirty = 1'b1;
                end
            end
            WRITE_BACK: cmd_base.word = cnt;
            FILL, FILL_WAIT: begin
                cmd_base.word      = ret_cnt;
                cmd_base.wdata_sel = 1'b1;
                cmd_base.write     = landing;
                cmd_base.fill      = landing && ret_cnt == LAST_WORD;
            end
            default: ;
        endcase
        cmd0 = cmd_base;
        cmd1 = cmd_base;
        // only the selected way takes the update
        if (way_sel) begin
            cmd0.write     = 1'b0;
            cmd0.fill      = 1'b0;
            cmd0.set_dirty = 1'b0;
        end else begin
            cmd1.write     = 1'b0;
            cmd1.fill      = 1'b0;
            cmd1.set_dirty = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            lru_q    <= '0;
            victim_q <= 1'b0;
            cnt      <= '0;
            ret_cnt  <= '0;
            pend     <= '0;
        end else begin
            state <= state_nxt;
            pend  <= {pend[`MEM_LAT-2:0], fill_accept};
            if (state == COMPARE && !hit_any) begin
                victim_q <= pick_way;
                cnt      <= '0;
                ret_cnt  <= '0;
            end
            if (mem_accept) begin
                cnt <= cnt + word_sel_t'(1);
            end
            if (landing) begin
                ret_cnt <= ret_cnt + word_sel_t'(1);
            end
            // LRU names the way not used
            if (done) begin
                lru_q[fields.index] <= ~way_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_addr <= Addr;
            req_data <= DataIn;
            req_wr   <= wr_req;
        end
    end

endmodule

//--- cache/cache_way.sv
/*
 * cache way
 * one way of the two-way data cache: tag, valid and dirty per set,
 * four data words per line, combinational read and tag compare
 */
`timescale 1ns/100ps
`include "mem_system_defines.svh"

module cache_way (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mem_system_pkg::addr_fields_t fields,
    input  mem_system_pkg::way_cmd_t     cmd,
    input  mem_system_pkg::data_t        cpu_wdata,
    input  mem_system_pkg::data_t        mem_rdata,
    output mem_system_pkg::way_status_t  status,
    output mem_system_pkg::data_t        rdata
);

    import mem_system_pkg::*;

    localparam int SETS = 1 << `INDEX_W;

    tag_t            tag_mem  [SETS];
    data_t           data_mem [SETS][`WORDS_PER_LINE];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    data_t           wdata;

    // lookup at the request index
    assign status.valid = valid_q[fields.index];
    assign status.dirty = dirty_q[fields.index];
    assign status.tag   = tag_mem[fields.index];
    assign status.hit   = valid_q[fields.index] && (tag_mem[fields.index] == fields.tag);

    assign rdata = data_mem[fields.index][cmd.word];
    assign wdata = cmd.wdata_sel ? mem_rdata : cpu_wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (cmd.fill) begin
            valid_q[fields.index] <= 1'b1;
        end
    end

    // fill brings in a clean line
    always_ff @(posedge clk) begin
        if (cmd.fill) begin
            dirty_q[fields.index] <= 1'b0;
        end else if (cmd.set_dirty) begin
            dirty_q[fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.fill) begin
            tag_mem[fields.index] <= fields.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.write) begin
            data_mem[fields.index][cmd.word] <= wdata;
        end
    end

endmodule

//--- common/mem_system_defines.svh
/*
 * memory system sizes
 * address split, word width and main memory timing
 */
`ifndef MEM_SYSTEM_DEFINES_SVH
`define MEM_SYSTEM_DEFINES_SVH

`define ADDR_W          16
`define DATA_W          16
`define TAG_W           5
`define INDEX_W         8
`define OFFSET_W        3
`define WORDS_PER_LINE  4

// cycles from accepted rd to data on the memory output
`define MEM_LAT         2
`define BANK_BUSY       4

`endif

//--- common/mem_system_pkg.sv
/*
 * memory system types
 * address fields, way status and command, memory request
 * and the cache controller states
 */
`include "mem_system_defines.svh"

package mem_system_pkg;

    typedef logic [`ADDR_W-1:0]  addr_t;
    typedef logic [`DATA_W-1:0]  data_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    // word in line, also the bank number
    typedef logic [`OFFSET_W-2:0] word_sel_t;

    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word;
        logic      byte_bit;
    } addr_fields_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        logic hit;
        tag_t tag;
    } way_status_t;

    typedef struct packed {
        logic      write;
        logic      fill;
        logic      set_dirty;
        word_sel_t word;
        logic      wdata_sel;  // 0 processor data, 1 memory data
    } way_cmd_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  rd;
        logic  wr;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE, COMPARE, WRITE_BACK, FILL, FILL_WAIT, RETRY, ERROR
    } ctrl_state_t;

endpackage

//--- list.f
+incdir+common
common/mem_system_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
src/four_bank_mem.sv
src/mem_system.sv
bench/mem_system_chk.sv
bench/mem_system_tb.sv

//--- src/four_bank_mem.sv
/*
 * four-bank main memory
 * word-interleaved banks with busy timers, writes stored at
 * acceptance and reads returned a fixed latency later
 */
`timescale 1ns/100ps
`include "mem_system_defines.svh"

module four_bank_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_system_pkg::mem_req_t req,
    output mem_system_pkg::data_t    rdata,
    output logic                     stall
);

    import mem_system_pkg::*;

    localparam int WORDS = 1 << (`ADDR_W - 1);
    localparam int BANKS = `WORDS_PER_LINE;
    localparam int CNT_W = $clog2(`BANK_BUSY + 1);

    data_t              mem     [WORDS];
    logic [CNT_W-1:0]   busy_q  [BANKS];
    logic [`ADDR_W-2:0] rd_line [`MEM_LAT];
    word_sel_t          bank;
    logic               accept;

    assign bank   = req.addr[2:1];
    assign stall  = busy_q[bank] != '0;
    assign accept = (req.rd || req.wr) && !stall;

    // data for the read issued MEM_LAT cycles ago
    assign rdata = mem[rd_line[`MEM_LAT-1]];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < BANKS; b++) begin
                busy_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (accept && bank == word_sel_t'(b)) begin
                    busy_q[b] <= CNT_W'(`BANK_BUSY);
                end else if (busy_q[b] != '0) begin
                    busy_q[b] <= busy_q[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req.wr) begin
            mem[req.addr[`ADDR_W-1:1]] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rd_line[0] <= req.addr[`ADDR_W-1:1];
        for (int i = 1; i < `MEM_LAT; i++) begin
            rd_line[i] <= rd_line[i-1];
        end
    end

endmodule

//--- src/mem_system.sv
/*
 * memory system top
 * two-way write-back data cache in front of four-bank main memory
 */
`timescale 1ns/100ps

module mem_system (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_system_pkg::addr_t Addr,
    input  mem_system_pkg::data_t DataIn,
    input  logic                  Rd,
    input  logic                  Wr,
    output mem_system_pkg::data_t DataOut,
    output logic                  Done,
    output logic                  Stall,
    output logic                  CacheHit,
    output logic                  err
);

    import mem_system_pkg::*;

    addr_fields_t fields;
    way_cmd_t     cmd0;
    way_cmd_t     cmd1;
    way_status_t  status0;
    way_status_t  status1;
    data_t        rdata0;
    data_t        rdata1;
    data_t        way_rdata;
    logic         way_sel;
    mem_req_t     mem_req;
    data_t        mem_rdata;
    logic         mem_stall;

    // word from the way the controller names
    assign way_rdata = way_sel ? rdata1 : rdata0;
    assign DataOut   = way_rdata;

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .Addr      (Addr),
        .DataIn    (DataIn),
        .rd_req    (Rd),
        .wr_req    (Wr),
        .status0   (status0),
        .status1   (status1),
        .way_rdata (way_rdata),
        .mem_stall (mem_stall),
        .fields    (fields),
        .cmd0      (cmd0),
        .cmd1      (cmd1),
        .way_sel   (way_sel),
        .mem_req   (mem_req),
        .done      (Done),
        .stall     (Stall),
        .cache_hit (CacheHit),
        .err       (err)
    );

    // processor write data arrives on the controller write bus
    cache_way u_way0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fields    (fields),
        .cmd       (cmd0),
        .cpu_wdata (mem_req.wdata),
        .mem_rdata (mem_rdata),
        .status    (status0),
        .rdata     (rdata0)
    );

    cache_way u_way1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fields    (fields),
        .cmd       (cmd1),
        .cpu_wdata (mem_req.wdata),
        .mem_rdata (mem_rdata),
        .status    (status1),
        .rdata     (rdata1)
    );

    four_bank_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rdata (mem_rdata),
        .stall (mem_stall)
    );

endmodule
